/* common/uart_defs.svh */
////////////////////////////////////////////////////////////
// UART peripheral shared parameters
// Data, bit-period and FIFO fill counter widths
// FIFO depth and register map offsets
////////////////////////////////////////////////////////////

`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

`define UART_DW      8   // Character width
`define UART_RW      8   // Bit period counter width
`define UART_FIFO_SZ 16  // FIFO depth
`define UART_CW      5   // Fill counter width, clog2(depth)+1

// Register map, 6-bit offsets
`define UART_ADR_TX_DAT 6'h00  // TX data, write only
`define UART_ADR_TX_CNT 6'h04  // TX FIFO fill
`define UART_ADR_TX_BDR 6'h08  // TX bit period
`define UART_ADR_TX_IRQ 6'h10  // TX interrupt threshold
`define UART_ADR_RX_DAT 6'h20  // RX data, read pops
`define UART_ADR_RX_CNT 6'h24  // RX FIFO fill
`define UART_ADR_RX_BDR 6'h28  // RX bit period
`define UART_ADR_RX_SMP 6'h2C  // RX sample phase
`define UART_ADR_RX_IRQ 6'h30  // RX interrupt threshold

`endif

/* common/uart_pkg.sv */
////////////////////////////////////////////////////////////
// UART peripheral package
// Width typedefs, bus request struct,
// deserializer state encoding
////////////////////////////////////////////////////////////

`include "uart_defs.svh"

package uart_pkg;

  typedef logic [`UART_DW-1:0] dat_t;  // One UART character
  typedef logic [`UART_RW-1:0] bdr_t;  // Bit period or sample phase, cycles minus one
  typedef logic [`UART_CW-1:0] cnt_t;  // FIFO fill or IRQ threshold
  typedef logic [6-1:0]        adr_t;  // Register offset
  typedef logic [32-1:0]       wrd_t;  // Bus data word

  // Host request, one transfer per cycle with vld high
  typedef struct packed {
    logic vld;  // Transfer request
    logic wen;  // Write enable, read when low
    adr_t adr;  // Register offset
    wrd_t wdt;  // Write data
  } bus_req_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    IDLE,   // Line high, waiting for falling edge
    START,  // Checking start bit
    DATA,   // Shifting in data bits
    STOP    // Checking stop bit
  } des_state_t;

endpackage

/* uart/uart_fifo.sv */
////////////////////////////////////////////////////////////
// UART synchronous FIFO
// Circular buffer, valid/ready on both sides,
// fill counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_fifo #(
  parameter int unsigned DEPTH = `UART_FIFO_SZ
)(
  input  logic           tcb,
  input  logic           rst,
  // Stream in
  input  logic           sti_vld,
  input  uart_pkg::dat_t sti_dat,
  output logic           sti_rdy,
  // Stream out
  output logic           sto_vld,
  output uart_pkg::dat_t sto_dat,
  input  logic           sto_rdy,
  // Fill level
  output uart_pkg::cnt_t cnt
);

  import uart_pkg::*;

  localparam int unsigned AW = $clog2(DEPTH);

  dat_t          mem [DEPTH];  // Storage
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic          push, pop;

  assign sti_rdy = (cnt != cnt_t'(DEPTH));  // Not full
  assign sto_vld = (cnt != '0);             // Not empty
  assign sto_dat = mem[rd_ptr];
  assign push    = sti_vld & sti_rdy;
  assign pop     = sto_vld & sto_rdy;

  always_ff @(posedge tcb) begin
    if (push) mem[wr_ptr] <= sti_dat;
  end

  always_ff @(posedge tcb) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
      if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: ;  // Idle or push and pop together
      endcase
    end
  end

  a_cnt_max: assert property (@(posedge tcb) disable iff (rst) cnt <= cnt_t'(DEPTH));

endmodule

/* uart/uart_regs.sv */
////////////////////////////////////////////////////////////
// UART register bank
// Offset decoder, configuration registers,
// registered read data, TX push and RX pop strobes,
// interrupt level compare
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_regs (
  input  logic              tcb,
  input  logic              rst,
  // Register bus
  input  uart_pkg::bus_req_t bus_req,
  output uart_pkg::wrd_t    bus_rdt,  // Valid 1 cycle after a read
  // TX FIFO push
  output logic              tx_vld,
  output uart_pkg::dat_t    tx_dat,
  // RX FIFO pop
  output logic              rx_rdy,
  input  logic              rx_vld,
  input  uart_pkg::dat_t    rx_dat,
  // FIFO fill levels
  input  uart_pkg::cnt_t    tx_cnt,
  input  uart_pkg::cnt_t    rx_cnt,
  // Configuration
  output uart_pkg::bdr_t    tx_bdr,
  output uart_pkg::bdr_t    rx_bdr,
  output uart_pkg::bdr_t    rx_smp,
  // Interrupts
  output logic              irq_tx,
  output logic              irq_rx
);

  import uart_pkg::*;

  logic bus_rd, bus_wr;  // Decoded transfer direction
  cnt_t tx_thr, rx_thr;  // Interrupt thresholds
  wrd_t rdt_mux;         // Read data before the register

  assign bus_rd = bus_req.vld & ~bus_req.wen;
  assign bus_wr = bus_req.vld &  bus_req.wen;

////////////////////////////////////////////////////////////
// Stream strobes
////////////////////////////////////////////////////////////

  assign tx_vld = bus_wr & (bus_req.adr == `UART_ADR_TX_DAT);  // Dropped by FIFO when full
  assign tx_dat = bus_req.wdt[`UART_DW-1:0];
  assign rx_rdy = bus_rd & (bus_req.adr == `UART_ADR_RX_DAT);  // Pop on request cycle

////////////////////////////////////////////////////////////
// Configuration writes
////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      tx_bdr <= '0;
      tx_thr <= '0;
      rx_bdr <= '0;
      rx_smp <= '0;
      rx_thr <= '0;
    end else if (bus_wr) begin
      case (bus_req.adr)
        `UART_ADR_TX_BDR: tx_bdr <= bus_req.wdt[`UART_RW-1:0];
        `UART_ADR_TX_IRQ: tx_thr <= bus_req.wdt[`UART_CW-1:0];
        `UART_ADR_RX_BDR: rx_bdr <= bus_req.wdt[`UART_RW-1:0];
        `UART_ADR_RX_SMP: rx_smp <= bus_req.wdt[`UART_RW-1:0];
        `UART_ADR_RX_IRQ: rx_thr <= bus_req.wdt[`UART_CW-1:0];
        default: ;  // TX data handled by strobe, rest read only
      endcase
    end
  end

////////////////////////////////////////////////////////////
// Read path
////////////////////////////////////////////////////////////

  always_comb begin
    case (bus_req.adr)
      `UART_ADR_TX_CNT: rdt_mux = wrd_t'(tx_cnt);
      `UART_ADR_TX_BDR: rdt_mux = wrd_t'(tx_bdr);
      `UART_ADR_TX_IRQ: rdt_mux = wrd_t'(tx_thr);
      `UART_ADR_RX_DAT: rdt_mux = rx_vld ? wrd_t'(rx_dat) : '0;  // Empty reads zero
      `UART_ADR_RX_CNT: rdt_mux = wrd_t'(rx_cnt);
      `UART_ADR_RX_BDR: rdt_mux = wrd_t'(rx_bdr);
      `UART_ADR_RX_SMP: rdt_mux = wrd_t'(rx_smp);
      `UART_ADR_RX_IRQ: rdt_mux = wrd_t'(rx_thr);
      default:          rdt_mux = '0;  // TX data and holes
    endcase
  end

  // Held until the next read
  always_ff @(posedge tcb) begin
    if (rst) begin
      bus_rdt <= '0;
    end else if (bus_rd) begin
      bus_rdt <= rdt_mux;
    end
  end

  // Level interrupts
  assign irq_tx = (tx_cnt < tx_thr);  // TX running low
  assign irq_rx = (rx_cnt > rx_thr);  // RX data waiting

  // A pop request that finds no data only while the RX FIFO is truly empty
  a_rx_pop_empty: assert property (@(posedge tcb) disable iff (rst)
    (rx_rdy && !rx_vld) |-> (rx_cnt == '0));

endmodule

/* uart/uart_ser.sv */
////////////////////////////////////////////////////////////
// UART serializer
// Start bit, data LSB first, one stop bit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_ser (
  input  logic           tcb,
  input  logic           rst,
  input  uart_pkg::bdr_t cfg_bdr,  // Bit period minus one
  // Byte stream
  input  logic           str_vld,
  input  uart_pkg::dat_t str_dat,
  output logic           str_rdy,
  // Serial line
  output logic           txd
);

  import uart_pkg::*;

  localparam int unsigned FW = `UART_DW + 2;  // Frame length in bits
  localparam int unsigned IW = $clog2(FW);

  logic          busy;
  bdr_t          cnt;  // Cycles into current bit
  logic [IW-1:0] idx;  // Bit index in frame
  logic [FW-1:0] shr;  // Frame shifter, LSB on the line

  assign str_rdy = ~busy;
  assign txd     = shr[0];

  always_ff @(posedge tcb) begin
    if (rst) begin
      busy <= 1'b0;
      cnt  <= '0;
      idx  <= '0;
      shr  <= '1;  // Line idles high
    end else if (str_vld && str_rdy) begin
      busy <= 1'b1;
      cnt  <= '0;
      idx  <= '0;
      shr  <= {1'b1, str_dat, 1'b0};  // Stop, data, start
    end else if (busy) begin
      if (cnt == cfg_bdr) begin
        cnt <= '0;
        shr <= {1'b1, shr[FW-1:1]};  // Ones fill behind the frame
        idx <= idx + 1'b1;
        if (idx == IW'(FW-1)) busy <= 1'b0;  // Stop bit done
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  a_idle_high: assert property (@(posedge tcb) disable iff (rst) !busy |-> txd);

endmodule

/* uart/uart_des.sv */
////////////////////////////////////////////////////////////
// UART deserializer
// Input synchronizer, start edge detect,
// sampling at programmed phase, byte output
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_des (
  input  logic           tcb,
  input  logic           rst,
  input  uart_pkg::bdr_t cfg_bdr,  // Bit period minus one
  input  uart_pkg::bdr_t cfg_smp,  // Sample phase within a bit
  input  logic           rxd,
  // Byte stream, no backpressure
  output logic           str_vld,
  output uart_pkg::dat_t str_dat
);

  import uart_pkg::*;

  localparam int unsigned IW = $clog2(`UART_DW);

  logic [1:0]    rxd_sync;  // Two-flop synchronizer
  logic          rxd_dly;   // For edge detect
  logic          rxd_s;
  logic          fall, smp, bit_end;
  des_state_t    state;
  bdr_t          cnt;       // Cycles into current bit
  logic [IW-1:0] idx;       // Data bit index
  dat_t          shr;

  assign rxd_s   = rxd_sync[1];
  assign fall    = rxd_dly & ~rxd_s;
  assign smp     = (cnt == cfg_smp);
  assign bit_end = (cnt == cfg_bdr);
  assign str_dat = shr;

  always_ff @(posedge tcb) begin
    if (rst) begin
      rxd_sync <= 2'b11;
      rxd_dly  <= 1'b1;
      state    <= IDLE;
      cnt      <= '0;
      idx      <= '0;
      str_vld  <= 1'b0;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      rxd_dly  <= rxd_s;
      str_vld  <= 1'b0;
      cnt      <= (state == IDLE || bit_end) ? '0 : cnt + 1'b1;
      case (state)
        IDLE:  if (fall) state <= START;
        START: begin
          if (smp && rxd_s) begin
            state <= IDLE;  // Glitch, not a start bit
          end else if (bit_end) begin
            state <= DATA;
            idx   <= '0;
          end
        end
        DATA: begin
          if (bit_end) begin
            idx <= idx + 1'b1;
            if (idx == IW'(`UART_DW-1)) state <= STOP;
          end
        end
        STOP: begin
          if (smp) begin
            str_vld <= rxd_s;  // Framing error drops the byte
            state   <= IDLE;   // Early exit to catch next start
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data shifter, LSB arrives first
  always_ff @(posedge tcb) begin
    if (state == DATA && smp) shr <= {rxd_s, shr[`UART_DW-1:1]};
  end

  a_vld_pulse: assert property (@(posedge tcb) disable iff (rst) str_vld |=> !str_vld);

endmodule

/* hdl/uart_top.sv */
////////////////////////////////////////////////////////////
// UART peripheral top level
// Register bank, TX and RX FIFOs,
// serializer and deserializer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_top (
  input  logic              tcb,
  input  logic              rst,
  // Register bus
  input  uart_pkg::bus_req_t bus_req,
  output uart_pkg::wrd_t    bus_rdt,
  // Serial line
  input  logic              uart_rxd,
  output logic              uart_txd,
  // Interrupts
  output logic              irq_tx,
  output logic              irq_rx
);

  import uart_pkg::*;

  logic tx_bus_vld, tx_str_vld, tx_str_rdy;  // TX path
  dat_t tx_bus_dat, tx_str_dat;
  logic rx_bus_vld, rx_bus_rdy, rx_str_vld;  // RX path
  dat_t rx_bus_dat, rx_str_dat;
  cnt_t tx_cnt, rx_cnt;
  bdr_t tx_bdr, rx_bdr, rx_smp;

  uart_regs regs (
    .tcb, .rst, .bus_req, .bus_rdt,
    .tx_vld (tx_bus_vld), .tx_dat (tx_bus_dat),
    .rx_rdy (rx_bus_rdy), .rx_vld (rx_bus_vld), .rx_dat (rx_bus_dat),
    .tx_cnt, .rx_cnt, .tx_bdr, .rx_bdr, .rx_smp,
    .irq_tx, .irq_rx
  );

  // Full FIFO drops host writes
  uart_fifo tx_fifo (
    .tcb, .rst,
    .sti_vld (tx_bus_vld), .sti_dat (tx_bus_dat), .sti_rdy (),
    .sto_vld (tx_str_vld), .sto_dat (tx_str_dat), .sto_rdy (tx_str_rdy),
    .cnt     (tx_cnt)
  );

  uart_ser tx_ser (
    .tcb, .rst, .cfg_bdr (tx_bdr),
    .str_vld (tx_str_vld), .str_dat (tx_str_dat), .str_rdy (tx_str_rdy),
    .txd     (uart_txd)
  );

  // Full FIFO drops received bytes
  uart_fifo rx_fifo (
    .tcb, .rst,
    .sti_vld (rx_str_vld), .sti_dat (rx_str_dat), .sti_rdy (),
    .sto_vld (rx_bus_vld), .sto_dat (rx_bus_dat), .sto_rdy (rx_bus_rdy),
    .cnt     (rx_cnt)
  );

  uart_des rx_des (
    .tcb, .rst, .cfg_bdr (rx_bdr), .cfg_smp (rx_smp),
    .rxd     (uart_rxd),
    .str_vld (rx_str_vld), .str_dat (rx_str_dat)
  );

endmodule

/* bench/uart_tb.sv */
////////////////////////////////////////////////////////////
// UART peripheral testbench
// Serial loopback, bus read and write tasks,
// value compare, interrupt and fill assertions,
// run timeout
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_tb;

  import uart_pkg::*;

  localparam int FRAME_FAST = 10 * 8;    // Frame at bdr 7
  localparam int FRAME_SLOW = 10 * 256;  // Frame at bdr 255
  localparam int RUN_LEN    = 8 * FRAME_FAST + 18 * FRAME_SLOW;  // Serial time of all tests
  localparam int TIMEOUT    = 2 * RUN_LEN;

  logic       tcb, rst;
  bus_req_t   bus_req;
  wrd_t       bus_rdt;
  logic       uart_line;               // txd looped to rxd
  logic       irq_tx, irq_rx;
  cnt_t       tx_thr_exp, rx_thr_exp;  // Thresholds as written
  string      test_name;
  int         tests, checks, errors, sva_errors, test_errors, cycles, got;
  integer     seed;
  wrd_t       rd;
  logic [9:0] frame;                   // Expected line bits, start first
  dat_t       sent [$];                // Bytes in flight, oldest first

  uart_top UUT (
    .tcb, .rst, .bus_req, .bus_rdt,
    .uart_rxd (uart_line), .uart_txd (uart_line),
    .irq_tx, .irq_rx
  );

  initial tcb = 1'b0;
  always #10 tcb = ~tcb;  // 20 ns period

////////////////////////////////////////////////////////////
// Bus and check tasks, called 1 ns after a rising edge
////////////////////////////////////////////////////////////

  task automatic bus_write(input adr_t adr, input wrd_t wdt);
    bus_req = '{vld: 1'b1, wen: 1'b1, adr: adr, wdt: wdt};
    @(posedge tcb);
    #1;
    bus_req.vld = 1'b0;  // Next call may raise it again, back to back
  endtask

  task automatic bus_read(input adr_t adr, output wrd_t rdt);
    bus_req = '{vld: 1'b1, wen: 1'b0, adr: adr, wdt: '0};
    @(posedge tcb);
    #1;
    bus_req.vld = 1'b0;
    rdt = bus_rdt;  // Registered on the request edge
  endtask

  task automatic check_val(input string item, input wrd_t exp, input wrd_t act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, item, exp, act);
    end
  endtask

  task automatic read_reg(input string item, input adr_t adr, input wrd_t exp);
    wrd_t rdt;
    bus_read(adr, rdt);
    check_val(item, exp, rdt);
  endtask

  task automatic send_bytes(input int n);
    dat_t b;
    for (int i = 0; i < n; i++) begin
      b = dat_t'($random(seed));
      sent.push_back(b);
      bus_write(`UART_ADR_TX_DAT, wrd_t'(b));
    end
  endtask

  task automatic wait_rx_cnt(input wrd_t target);
    wrd_t cnt;
    do begin
      bus_read(`UART_ADR_RX_CNT, cnt);  // Poll, timeout guards the loop
    end while (cnt != target);
  endtask

  task automatic drain_rx(input int n);
    wrd_t dat;
    for (int i = 0; i < n; i++) begin
      bus_read(`UART_ADR_RX_DAT, dat);
      check_val("rx data", wrd_t'(sent.pop_front()), dat);
    end
  endtask

  task automatic finish_test();
    tests++;
    $display("test %s finished, %0d errors", test_name, errors + sva_errors - test_errors);
    test_errors = errors + sva_errors;
  endtask

////////////////////////////////////////////////////////////
// Interrupt levels and TX fill bound
////////////////////////////////////////////////////////////

  a_irq_tx: assert property (@(posedge tcb) disable iff (rst)
    irq_tx == (UUT.tx_cnt < tx_thr_exp))
    else begin
      sva_errors++;
      $display("mismatch %s irq_tx: expected %0b, actual %0b",
               test_name, !$sampled(irq_tx), $sampled(irq_tx));
    end

  a_irq_rx: assert property (@(posedge tcb) disable iff (rst)
    irq_rx == (UUT.rx_cnt > rx_thr_exp))
    else begin
      sva_errors++;
      $display("mismatch %s irq_rx: expected %0b, actual %0b",
               test_name, !$sampled(irq_rx), $sampled(irq_rx));
    end

  a_tx_fill: assert property (@(posedge tcb) disable iff (rst)
    UUT.tx_cnt <= cnt_t'(`UART_FIFO_SZ))
    else begin
      sva_errors++;
      $display("TX FIFO fill count went above the FIFO depth in test %s", test_name);
    end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge tcb);
      cycles++;
    end
    $display("timeout: test %s did not finish within %0d cycles", test_name, TIMEOUT);
    $display("ERRORS FOUND");
    $finish;
  end

////////////////////////////////////////////////////////////
// Test sequence
////////////////////////////////////////////////////////////

  initial begin
    seed        = 64;
    rst         = 1'b1;
    bus_req     = '0;
    tx_thr_exp  = '0;
    rx_thr_exp  = '0;
    tests       = 0;
    checks      = 0;
    errors      = 0;
    sva_errors  = 0;
    test_errors = 0;
    test_name   = "reset";
    repeat (5) @(posedge tcb);
    #1;
    rst = 1'b0;

    read_reg("tx count", `UART_ADR_TX_CNT, 0);
    read_reg("tx bdr", `UART_ADR_TX_BDR, 0);
    read_reg("tx threshold", `UART_ADR_TX_IRQ, 0);
    read_reg("rx count", `UART_ADR_RX_CNT, 0);
    read_reg("rx bdr", `UART_ADR_RX_BDR, 0);
    read_reg("rx smp", `UART_ADR_RX_SMP, 0);
    read_reg("rx threshold", `UART_ADR_RX_IRQ, 0);
    check_val("txd", 1, wrd_t'(uart_line));
    check_val("irq_tx", 0, wrd_t'(irq_tx));
    check_val("irq_rx", 0, wrd_t'(irq_rx));
    finish_test();

    test_name = "config";
    bus_write(`UART_ADR_TX_BDR, 7);
    bus_write(`UART_ADR_RX_BDR, 7);
    bus_write(`UART_ADR_RX_SMP, 3);  // Near mid-bit
    bus_write(`UART_ADR_TX_IRQ, 2);
    tx_thr_exp = 2;                  // Register took it on the last edge
    bus_write(`UART_ADR_RX_IRQ, 0);
    rx_thr_exp = 0;
    read_reg("tx bdr", `UART_ADR_TX_BDR, 7);
    read_reg("rx bdr", `UART_ADR_RX_BDR, 7);
    read_reg("rx smp", `UART_ADR_RX_SMP, 3);
    read_reg("tx threshold", `UART_ADR_TX_IRQ, 2);
    read_reg("rx threshold", `UART_ADR_RX_IRQ, 0);
    finish_test();

    test_name = "frame";
    send_bytes(1);
    frame = {1'b1, sent[0], 1'b0};  // Stop, data, start
    @(negedge uart_line);           // Start bit begins
    repeat (4) @(posedge tcb);      // Half of an 8-cycle bit
    #1;
    for (int i = 0; i < 10; i++) begin
      check_val($sformatf("txd bit %0d", i), wrd_t'(frame[i]), wrd_t'(uart_line));
      repeat (8) @(posedge tcb);
      #1;
    end
    wait_rx_cnt(1);
    drain_rx(1);
    finish_test();

    test_name = "loopback";
    send_bytes(4);
    wait_rx_cnt(4);
    drain_rx(4);                    // Same order as written
    read_reg("rx count", `UART_ADR_RX_CNT, 0);
    finish_test();

    test_name = "irq";
    check_val("irq_tx empty", 1, wrd_t'(irq_tx));
    check_val("irq_rx empty", 0, wrd_t'(irq_rx));
    send_bytes(3);                  // One taken by the serializer
    read_reg("tx count", `UART_ADR_TX_CNT, 2);
    check_val("irq_tx at threshold", 0, wrd_t'(irq_tx));
    wait_rx_cnt(3);
    check_val("irq_rx with data", 1, wrd_t'(irq_rx));
    drain_rx(3);
    check_val("irq_rx drained", 0, wrd_t'(irq_rx));
    check_val("irq_tx drained", 1, wrd_t'(irq_tx));
    finish_test();

    test_name = "overflow";
    bus_write(`UART_ADR_TX_BDR, 255);
    bus_write(`UART_ADR_RX_BDR, 255);
    bus_write(`UART_ADR_RX_SMP, 127);
    send_bytes(20);                 // Last three find the FIFO full
    read_reg("tx count", `UART_ADR_TX_CNT, `UART_FIFO_SZ);
    got = 0;
    while (got < `UART_FIFO_SZ + 1) begin  // Queued plus the one in flight
      bus_read(`UART_ADR_RX_CNT, rd);
      if (rd != 0) begin
        drain_rx(1);
        got++;
      end
    end
    repeat (FRAME_SLOW) @(posedge tcb);  // Room for a stray frame
    #1;
    read_reg("rx count after drops", `UART_ADR_RX_CNT, 0);
    read_reg("tx count after drops", `UART_ADR_TX_CNT, 0);
    sent.delete();                  // Dropped writes
    finish_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + sva_errors);
    if (errors + sva_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* uart_ctl.f */
+incdir+common
common/uart_pkg.sv
uart/uart_fifo.sv
uart/uart_regs.sv
uart/uart_ser.sv
uart/uart_des.sv
hdl/uart_top.sv
bench/uart_tb.sv

/* Makefile */
# Verilator build and run of the UART peripheral testbench

VERILATOR ?= verilator
TOP       ?= uart_tb
FLIST     ?= uart_ctl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
